// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module cache_tb -Mdir obj_dir

out=$(./obj_dir/Vcache_tb || true)
echo "$out"

if grep -q "Result: PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi

// ==== verif/cache_mem_model.sv ====
//====================
// line-wide memory on the cache memory port, one request at a time
// unwritten words read as their address xor 0x5a5a0000
//====================
`timescale 1ns/100ps

module cache_mem_model (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    memreq_val,
  output logic                    memreq_rdy,
  input  cache_pkg::mem_req_t     memreq_msg,
  output logic                    memresp_val,
  input  logic                    memresp_rdy,
  output cache_pkg::mem_resp_t    memresp_msg
);

  logic [cache_pkg::line_w-1:0] lines [logic [31:0]];
  logic [31:0]                  seed        = 32'd12;
  logic                         rdy_q       = 1'b0;
  logic                         val_q       = 1'b0;
  logic                         busy        = 1'b0;
  int                           delay       = 0;
  logic [cache_pkg::line_w-1:0] line_q      = '0;
  logic                         req_fire_q  = 1'b0;
  logic                         resp_fire_q = 1'b0;
  cache_pkg::mem_req_t          req_q       = '0;

  assign memreq_rdy  = rdy_q;
  assign memresp_val = val_q;
  assign memresp_msg = '{line: line_q};

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    next_rand = s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [cache_pkg::line_w-1:0] read_line(input logic [31:0] base);
    logic [cache_pkg::line_w-1:0] l;
    if (lines.exists(base))
      return lines[base];
    for (int k = 0; k < cache_pkg::words_per_line; k++)
    begin
      l[32*k +: 32] = (base + 32'(4 * k)) ^ 32'h5A5A0000;
    end
    return l;
  endfunction

  // transfers are seen on the rising edge
  always @(posedge clk)
  begin
    req_fire_q  <= memreq_val && rdy_q;
    resp_fire_q <= val_q && memresp_rdy;
    req_q       <= memreq_msg;
  end

  // outputs change on the falling edge
  always @(negedge clk)
  begin
    if (reset)
    begin
      rdy_q = 1'b0;
      val_q = 1'b0;
      busy  = 1'b0;
    end
    else
    begin
      seed = next_rand(seed);
      if (resp_fire_q)
      begin
        val_q = 1'b0;
        busy  = 1'b0;
      end
      if (req_fire_q)
      begin
        busy  = 1'b1;
        delay = int'(seed[18:17]);
        if (req_q.req_type == cache_pkg::req_write)
        begin
          lines[req_q.addr] = req_q.line;
          line_q = '0;
        end
        else
          line_q = read_line(req_q.addr);
      end
      else if (busy && !val_q)
      begin
        if (delay == 0)
          val_q = 1'b1;
        else
          delay--;
      end
      rdy_q = !busy && seed[16];
    end
  end

endmodule

// ==== verif/cache_tb.sv ====
//====================
// directed table then 40 random accesses, checked against a reference model
// write responses carry zero data
//====================
`timescale 1ns/100ps

module cache_tb;

  localparam int timeout = 300;

  typedef struct packed {
    cache_pkg::req_type_e  req_type;
    logic [31:0]           addr;
    logic [31:0]           data;
    int                    hold;
    logic                  use_model;
    logic                  exp_hit;
    logic [31:0]           exp_data;
  } stim_t;

  logic                    clk;
  logic                    reset;
  logic                    cachereq_val;
  logic                    cachereq_rdy;
  cache_pkg::cache_req_t   cachereq_msg;
  logic                    cacheresp_val;
  logic                    cacheresp_rdy;
  cache_pkg::cache_resp_t  cacheresp_msg;
  logic                    memreq_val;
  logic                    memreq_rdy;
  cache_pkg::mem_req_t     memreq_msg;
  logic                    memresp_val;
  logic                    memresp_rdy;
  cache_pkg::mem_resp_t    memresp_msg;

  stim_t                   table_q [$];

  // reference model
  logic [31:0]             ref_mem [logic [31:0]];
  logic                    ref_valid [cache_pkg::num_sets][2];
  logic                    ref_dirty [cache_pkg::num_sets][2];
  logic [24:0]             ref_tag   [cache_pkg::num_sets][2];
  logic                    ref_lru   [cache_pkg::num_sets];

  // expected memory traffic of the request in flight
  logic [31:0]             cur_addr;
  int                      exp_wb_count;
  int                      wb_seen;
  logic [31:0]             exp_wb_addr;
  logic [127:0]            exp_wb_line;

  blocking_cache dut_i (.*);

  cache_mem_model mem_i (
    .clk(clk), .reset(reset),
    .memreq_val(memreq_val), .memreq_rdy(memreq_rdy), .memreq_msg(memreq_msg),
    .memresp_val(memresp_val), .memresp_rdy(memresp_rdy), .memresp_msg(memresp_msg)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  //====================
  // helpers
  //====================
  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    lcg_step = s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    if (ref_mem.exists(a))
      return ref_mem[a];
    return a ^ 32'h5A5A0000;
  endfunction

  task automatic add_entry(input cache_pkg::req_type_e t, input logic [31:0] a,
                           input logic [31:0] d, input int hold, input logic use_model,
                           input logic hit, input logic [31:0] rdata);
    stim_t e;
    e = '{req_type: t, addr: a, data: d, hold: hold,
          use_model: use_model, exp_hit: hit, exp_data: rdata};
    table_q.push_back(e);
  endtask

  // same LRU rule as the cache: an access makes the other way the victim
  task automatic predict(input stim_t s, output cache_pkg::cache_resp_t exp);
    logic [2:0]  idx;
    logic [24:0] tag;
    logic        way;
    logic        hit;
    idx = s.addr[6:4];
    tag = s.addr[31:7];
    hit = 1'b0;
    way = ref_lru[idx];
    exp_wb_count = 0;
    for (int w = 0; w < 2; w++)
    begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == tag)
      begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit)
    begin
      if (ref_valid[idx][way] && ref_dirty[idx][way])
      begin
        exp_wb_count = 1;
        exp_wb_addr  = {ref_tag[idx][way], idx, 4'h0};
        for (int k = 0; k < 4; k++)
          exp_wb_line[32*k +: 32] = ref_word(exp_wb_addr + 32'(4 * k));
      end
      ref_valid[idx][way] = 1'b1;
      ref_dirty[idx][way] = 1'b0;
      ref_tag[idx][way]   = tag;
    end
    exp.resp_type = s.req_type;
    exp.hit       = hit;
    if (s.req_type == cache_pkg::req_write)
    begin
      ref_mem[s.addr]     = s.data;
      ref_dirty[idx][way] = 1'b1;
      exp.data            = '0;
    end
    else
      exp.data = ref_word(s.addr);
    ref_lru[idx] = ~way;
    if (!s.use_model)
    begin
      exp.hit  = s.exp_hit;
      exp.data = s.exp_data;
    end
  endtask

  //====================
  // compare tasks
  //====================
  task automatic check_resp(input cache_pkg::cache_resp_t got,
                            input cache_pkg::cache_resp_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("mismatch at %0t: %s addr %h got type %0d hit %0b data %h, %s",
                         $time, what, cur_addr, got.resp_type, got.hit, got.data,
                         $sformatf("expected type %0d hit %0b data %h",
                                   exp.resp_type, exp.hit, exp.data)));
  endtask

  task automatic check_mem_req(input cache_pkg::mem_req_t m);
    if (m.req_type == cache_pkg::req_write)
    begin
      if (wb_seen >= exp_wb_count)
        fail_run($sformatf("mismatch at %0t: unexpected write-back to %h", $time, m.addr));
      if (m.addr !== exp_wb_addr)
        fail_run($sformatf("mismatch at %0t: write-back addr %h, expected %h",
                           $time, m.addr, exp_wb_addr));
      if (m.line !== exp_wb_line)
        fail_run($sformatf("mismatch at %0t: write-back line %h, expected %h",
                           $time, m.line, exp_wb_line));
      wb_seen++;
    end
    else if (m.addr !== {cur_addr[31:4], 4'h0})
      fail_run($sformatf("mismatch at %0t: refill addr %h for request %h",
                         $time, m.addr, cur_addr));
  endtask

  // bits are cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy
  task automatic verify_handshake(input logic [3:0] exp, input string what);
    logic [3:0] got;
    got = {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy};
    if (got !== exp)
      fail_run($sformatf("mismatch at %0t: %s handshake %b, expected %b",
                         $time, what, got, exp));
  endtask

  always @(posedge clk)
  begin
    if (!reset && memreq_val && memreq_rdy)
      check_mem_req(memreq_msg);
  end

  // called on a falling edge, returns on a falling edge
  task automatic run_entry(input stim_t s);
    cache_pkg::cache_resp_t exp;
    cache_pkg::cache_resp_t first;
    int                     waited;
    predict(s, exp);
    wb_seen      = 0;
    cur_addr     = s.addr;
    cachereq_msg = '{req_type: s.req_type, addr: s.addr, data: s.data};
    cachereq_val = 1'b1;
    waited = 0;
    while (!cachereq_rdy)
    begin
      @(negedge clk);
      waited++;
      if (waited > timeout)
        fail_run("timeout: the cache never accepted a request");
    end
    @(negedge clk);
    cachereq_val = 1'b0;
    waited = 0;
    while (!cacheresp_val)
    begin
      @(negedge clk);
      waited++;
      if (waited > timeout)
        fail_run("timeout: the cache never returned a response");
    end
    first = cacheresp_msg;
    verify_handshake(4'b0100, "response");
    // back-pressure must freeze the response
    for (int d = 0; d < s.hold; d++)
    begin
      @(negedge clk);
      if (!cacheresp_val)
        fail_run("response valid dropped while the response was not taken");
      verify_handshake(4'b0100, "held response");
      check_resp(cacheresp_msg, first, "held response");
    end
    cacheresp_rdy = 1'b1;
    check_resp(first, exp, "response");
    @(negedge clk);
    cacheresp_rdy = 1'b0;
    if (wb_seen != exp_wb_count)
      fail_run($sformatf("mismatch at %0t: %0d write-backs for %h, expected %0d",
                         $time, wb_seen, s.addr, exp_wb_count));
  endtask

  //====================
  // stimulus
  //====================
  initial
  begin
    logic [31:0] r;
    logic [31:0] k;
    logic [31:0] a;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_msg  = '0;
    cacheresp_rdy = 1'b0;
    exp_wb_count  = 0;
    wb_seen       = 0;
    cur_addr      = '0;
    exp_wb_addr   = '0;
    exp_wb_line   = '0;
    for (int i = 0; i < cache_pkg::num_sets; i++)
    begin
      ref_lru[i] = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
        ref_valid[i][w] = 1'b0;
        ref_dirty[i][w] = 1'b0;
        ref_tag[i][w]   = '0;
      end
    end

    // set 1 with tags 0, 1, 2 and 4
    add_entry(cache_pkg::req_read,  32'h010, 32'h0, 0, 1'b0, 1'b0, 32'h5A5A0010);
    add_entry(cache_pkg::req_read,  32'h014, 32'h0, 0, 1'b0, 1'b1, 32'h5A5A0014);
    add_entry(cache_pkg::req_write, 32'h018, 32'hDEADBEEF, 0, 1'b0, 1'b1, 32'h0);
    add_entry(cache_pkg::req_read,  32'h018, 32'h0, 5, 1'b0, 1'b1, 32'hDEADBEEF);
    add_entry(cache_pkg::req_read,  32'h090, 32'h0, 0, 1'b0, 1'b0, 32'h5A5A0090);
    add_entry(cache_pkg::req_read,  32'h094, 32'h0, 0, 1'b0, 1'b1, 32'h5A5A0094);
    // dirty line 0x10 is the LRU victim here
    add_entry(cache_pkg::req_read,  32'h110, 32'h0, 0, 1'b0, 1'b0, 32'h5A5A0110);
    add_entry(cache_pkg::req_read,  32'h090, 32'h0, 0, 1'b0, 1'b1, 32'h5A5A0090);
    add_entry(cache_pkg::req_read,  32'h018, 32'h0, 0, 1'b0, 1'b0, 32'hDEADBEEF);
    add_entry(cache_pkg::req_read,  32'h110, 32'h0, 0, 1'b0, 1'b0, 32'h5A5A0110);
    add_entry(cache_pkg::req_write, 32'h210, 32'h12345678, 2, 1'b0, 1'b0, 32'h0);
    add_entry(cache_pkg::req_read,  32'h210, 32'h0, 0, 1'b0, 1'b1, 32'h12345678);

    // 24 addresses: six tags, sets 2 and 3, words 0 and 1
    r = 32'd12;
    for (int i = 0; i < 40; i++)
    begin
      r = lcg_step(r);
      k = (r >> 8) % 32'd24;
      a = ((k % 32'd6) << 7) | ((32'd2 + (k / 32'd6) % 32'd2) << 4) | ((k / 32'd12) << 2);
      add_entry(r[20] ? cache_pkg::req_write : cache_pkg::req_read, a, lcg_step(r),
                int'((r >> 16) % 32'd3), 1'b1, 1'b0, 32'h0);
    end

    repeat (16)
      @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    verify_handshake(4'b1000, "after reset");

    foreach (table_q[i])
      run_entry(table_q[i]);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog/blocking_cache.sv ====
//====================
// blocking two-way write-back cache, one request in flight
// both ports use valid/ready, a write-back also gets a memory response
//====================
`timescale 1ns/100ps

module blocking_cache (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cachereq_val,
  output logic                      cachereq_rdy,
  input  cache_pkg::cache_req_t     cachereq_msg,
  output logic                      cacheresp_val,
  input  logic                      cacheresp_rdy,
  output cache_pkg::cache_resp_t    cacheresp_msg,
  output logic                      memreq_val,
  input  logic                      memreq_rdy,
  output cache_pkg::mem_req_t       memreq_msg,
  input  logic                      memresp_val,
  output logic                      memresp_rdy,
  input  cache_pkg::mem_resp_t      memresp_msg
);

  cache_pkg::dp_ctrl_t                    ctrl;
  cache_pkg::tag_status_t                 status;
  logic [cache_pkg::addr_w-1:0]           addr;
  logic                                   req_write;
  logic [cache_pkg::index_w-1:0]          index;
  logic [cache_pkg::line_w-1:0]           line_wdata;
  cache_pkg::tag_entry_t                  tag_wdata;
  cache_pkg::tag_entry_t [1:0]            way_tags;
  logic [1:0][cache_pkg::line_w-1:0]      way_lines;
  logic [1:0]                             way_wen;

  assign index = addr[cache_pkg::offset_w +: cache_pkg::index_w];

  cache_ctrl ctrl_i (
    .clk(clk), .reset(reset),
    .cachereq_val(cachereq_val), .cachereq_rdy(cachereq_rdy),
    .cacheresp_val(cacheresp_val), .cacheresp_rdy(cacheresp_rdy),
    .memreq_val(memreq_val), .memreq_rdy(memreq_rdy),
    .memresp_val(memresp_val), .memresp_rdy(memresp_rdy),
    .status(status), .ctrl(ctrl)
  );

  cache_tag_check tag_check_i (
    .clk(clk), .reset(reset), .addr(addr), .write(req_write),
    .way_tags(way_tags), .ctrl(ctrl), .status(status)
  );

  cache_datapath datapath_i (
    .clk(clk), .reset(reset), .cachereq_msg(cachereq_msg), .ctrl(ctrl),
    .status(status), .way_lines(way_lines), .memresp_msg(memresp_msg),
    .addr(addr), .req_write(req_write), .line_wdata(line_wdata),
    .tag_wdata(tag_wdata), .memreq_msg(memreq_msg), .cacheresp_msg(cacheresp_msg)
  );

  //====================
  // way storage
  //====================
  for (genvar w = 0; w < 2; w++)
  begin : g_way
    // only the way named in the status is written
    assign way_wen[w] = ctrl.line_wen && (status.way == 1'(w));

    cache_way_array #(.entry_t(cache_pkg::tag_entry_t)) tag_way_i (
      .clk(clk), .index(index), .wen(way_wen[w]),
      .wdata(tag_wdata), .rdata(way_tags[w])
    );

    cache_way_array #(.entry_t(logic [cache_pkg::line_w-1:0])) data_way_i (
      .clk(clk), .index(index), .wen(way_wen[w]),
      .wdata(line_wdata), .rdata(way_lines[w])
    );
  end

endmodule

// ==== verilog/cache_ctrl.sv ====
//====================
// FSM for one request at a time, outputs decoded from the state only
// a write-back response is taken and dropped before the refill starts
//====================
`timescale 1ns/100ps

module cache_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cachereq_val,
  output logic                      cachereq_rdy,
  output logic                      cacheresp_val,
  input  logic                      cacheresp_rdy,
  output logic                      memreq_val,
  input  logic                      memreq_rdy,
  input  logic                      memresp_val,
  output logic                      memresp_rdy,
  input  cache_pkg::tag_status_t    status,
  output cache_pkg::dp_ctrl_t       ctrl
);

  cache_pkg::ctrl_state_e state_q;
  cache_pkg::ctrl_state_e state_n;

  always_ff @(posedge clk)
  begin
    if (reset)
      state_q <= cache_pkg::st_idle;
    else
      state_q <= state_n;
  end

  //====================
  // next state
  //====================
  always_comb
  begin
    state_n = state_q;
    case (state_q)
      cache_pkg::st_idle:
        if (cachereq_val)
          state_n = cache_pkg::st_tag_check;
      cache_pkg::st_tag_check:
        if (status.hit)
          state_n = cache_pkg::st_data_access;
        else if (status.victim_dirty)
          state_n = cache_pkg::st_evict_req;
        else
          state_n = cache_pkg::st_refill_req;
      cache_pkg::st_data_access:
        state_n = cache_pkg::st_resp_wait;
      cache_pkg::st_evict_req:
        if (memreq_rdy)
          state_n = cache_pkg::st_evict_wait;
      cache_pkg::st_evict_wait:
        if (memresp_val)
          state_n = cache_pkg::st_refill_req;
      cache_pkg::st_refill_req:
        if (memreq_rdy)
          state_n = cache_pkg::st_refill_wait;
      cache_pkg::st_refill_wait:
        if (memresp_val)
          state_n = cache_pkg::st_refill_update;
      // go through the access again, it hits now
      cache_pkg::st_refill_update:
        state_n = cache_pkg::st_data_access;
      cache_pkg::st_resp_wait:
        if (cacheresp_rdy)
          state_n = cache_pkg::st_idle;
      default:
        state_n = cache_pkg::st_idle;
    endcase
  end

  //====================
  // outputs
  //====================
  always_comb
  begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    ctrl          = '0;
    case (state_q)
      cache_pkg::st_idle:
      begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = 1'b1;
      end
      // a read writes back the unchanged line, a write the merged one
      cache_pkg::st_data_access:
      begin
        ctrl.line_wen = 1'b1;
        ctrl.read_en  = 1'b1;
        ctrl.touch    = 1'b1;
      end
      cache_pkg::st_evict_req:
      begin
        memreq_val     = 1'b1;
        ctrl.evict_sel = 1'b1;
      end
      cache_pkg::st_evict_wait:
      begin
        memresp_rdy = 1'b1;
      end
      cache_pkg::st_refill_req:
      begin
        memreq_val = 1'b1;
      end
      // line is captured on every cycle here, the last one is the transfer
      cache_pkg::st_refill_wait:
      begin
        memresp_rdy  = 1'b1;
        ctrl.fill_en = 1'b1;
      end
      cache_pkg::st_refill_update:
      begin
        ctrl.line_wen    = 1'b1;
        ctrl.refill_sel  = 1'b1;
        ctrl.clean_evict = 1'b1;
      end
      cache_pkg::st_resp_wait:
      begin
        cacheresp_val = 1'b1;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== verilog/cache_datapath.sv ====
//====================
// holds the request in flight and builds array, memory and response data
// messages come from registers or the arrays, so they hold under back-pressure
//====================
`timescale 1ns/100ps

module cache_datapath (
  input  logic                                clk,
  input  logic                                reset,
  input  cache_pkg::cache_req_t               cachereq_msg,
  input  cache_pkg::dp_ctrl_t                 ctrl,
  input  cache_pkg::tag_status_t              status,
  input  logic [1:0][cache_pkg::line_w-1:0]   way_lines,
  input  cache_pkg::mem_resp_t                memresp_msg,
  output logic [cache_pkg::addr_w-1:0]        addr,
  output logic                                req_write,
  output logic [cache_pkg::line_w-1:0]        line_wdata,
  output cache_pkg::tag_entry_t               tag_wdata,
  output cache_pkg::mem_req_t                 memreq_msg,
  output cache_pkg::cache_resp_t              cacheresp_msg
);

  localparam int word_sel_w = $clog2(cache_pkg::words_per_line);
  localparam int byte_sel_w = $clog2(cache_pkg::data_w / 8);

  cache_pkg::cache_req_t                                          req_q;
  logic [cache_pkg::line_w-1:0]                                   fill_q;
  logic [cache_pkg::data_w-1:0]                                   read_q;
  logic                                                           first_q;
  logic                                                           hit_q;
  logic [cache_pkg::index_w-1:0]                                  index;
  logic [cache_pkg::tag_w-1:0]                                    req_tag;
  logic [word_sel_w-1:0]                                          word_off;
  logic [cache_pkg::words_per_line-1:0][cache_pkg::data_w-1:0]    sel_words;
  logic [cache_pkg::words_per_line-1:0][cache_pkg::data_w-1:0]    merged_words;

  //====================
  // registers
  //====================
  always_ff @(posedge clk)
  begin
    if (ctrl.req_en)
      req_q <= cachereq_msg;
    if (ctrl.fill_en)
      fill_q <= memresp_msg.line;
    if (ctrl.read_en)
      read_q <= sel_words[word_off];
    // only the first tag check counts as a hit
    if (first_q)
      hit_q <= status.hit;
  end

  // marks the cycle right after the request was taken
  always_ff @(posedge clk)
  begin
    if (reset)
      first_q <= 1'b0;
    else
      first_q <= ctrl.req_en;
  end

  assign addr      = req_q.addr;
  assign req_write = (req_q.req_type == cache_pkg::req_write);
  assign index     = req_q.addr[cache_pkg::offset_w +: cache_pkg::index_w];
  assign req_tag   = req_q.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
  assign word_off  = req_q.addr[byte_sel_w +: word_sel_w];
  assign sel_words = way_lines[status.way];

  //====================
  // line and tag write data
  //====================
  always_comb
  begin
    merged_words = sel_words;
    if (req_write)
      merged_words[word_off] = req_q.data;
  end

  assign line_wdata = ctrl.refill_sel ? fill_q : merged_words;
  assign tag_wdata  = '{tag: req_tag};

  // write-back sends the victim line, refill asks for the request line
  always_comb
  begin
    if (ctrl.evict_sel)
    begin
      memreq_msg.req_type = cache_pkg::req_write;
      memreq_msg.addr     = {status.victim_tag, index, {cache_pkg::offset_w{1'b0}}};
      memreq_msg.line     = sel_words;
    end
    else
    begin
      memreq_msg.req_type = cache_pkg::req_read;
      memreq_msg.addr     = {req_tag, index, {cache_pkg::offset_w{1'b0}}};
      memreq_msg.line     = '0;
    end
  end

  always_comb
  begin
    cacheresp_msg.resp_type = req_q.req_type;
    cacheresp_msg.hit       = hit_q;
    cacheresp_msg.data      = req_write ? '0 : read_q;
  end

endmodule

// ==== verilog/cache_pkg.sv ====
//====================
// 256-byte two-way cache with 16-byte lines and 32-bit words
// the geometry values depend on each other and are not rescaled together
//====================
package cache_pkg;

  //====================
  // geometry
  //====================
  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int line_w         = 128;
  localparam int offset_w       = 4;
  localparam int index_w        = 3;
  localparam int num_sets       = 8;
  localparam int tag_w          = 25;
  localparam int words_per_line = 4;

  // on the memory port read is a refill and write is a write-back
  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_type_e;

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_data_access,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_update,
    st_resp_wait
  } ctrl_state_e;

  //====================
  // port messages
  //====================
  typedef struct packed {
    req_type_e           req_type;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    req_type_e           resp_type;
    logic                hit;
    logic [data_w-1:0]   data;
  } cache_resp_t;

  // addr is always line aligned
  typedef struct packed {
    req_type_e           req_type;
    logic [addr_w-1:0]   addr;
    logic [line_w-1:0]   line;
  } mem_req_t;

  typedef struct packed {
    logic [line_w-1:0]   line;
  } mem_resp_t;

  //====================
  // internal bundles
  //====================
  typedef struct packed {
    logic [tag_w-1:0]    tag;
  } tag_entry_t;

  // way is the hit way on a hit, otherwise the LRU victim
  typedef struct packed {
    logic                hit;
    logic                way;
    logic                victim_dirty;
    logic [tag_w-1:0]    victim_tag;
  } tag_status_t;

  typedef struct packed {
    logic                req_en;
    logic                line_wen;
    logic                refill_sel;
    logic                fill_en;
    logic                read_en;
    logic                touch;
    logic                evict_sel;
    logic                clean_evict;
  } dp_ctrl_t;

endpackage

// ==== verilog/cache_tag_check.sv ====
//====================
// valid, dirty and LRU state per set plus the two-way tag compare
// lru_q names the way to replace next in each set
//====================
`timescale 1ns/100ps

module cache_tag_check (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cache_pkg::addr_w-1:0]    addr,
  input  logic                            write,
  input  cache_pkg::tag_entry_t [1:0]     way_tags,
  input  cache_pkg::dp_ctrl_t             ctrl,
  output cache_pkg::tag_status_t          status
);

  logic [1:0][cache_pkg::num_sets-1:0]    valid_q;
  logic [1:0][cache_pkg::num_sets-1:0]    dirty_q;
  logic [cache_pkg::num_sets-1:0]         lru_q;
  logic [cache_pkg::index_w-1:0]          index;
  logic [cache_pkg::tag_w-1:0]            tag;
  logic [1:0]                             match;
  logic                                   hit;
  logic                                   victim;
  logic                                   way;

  assign index = addr[cache_pkg::offset_w +: cache_pkg::index_w];
  assign tag   = addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];

  //====================
  // compare
  //====================
  always_comb
  begin
    for (int w = 0; w < 2; w++)
    begin
      match[w] = valid_q[w][index] && (way_tags[w].tag == tag);
    end
  end

  assign hit    = |match;
  assign victim = lru_q[index];

  // with one match, match[1] is the way number
  assign way = hit ? match[1] : victim;

  always_comb
  begin
    status.hit          = hit;
    status.way          = way;
    status.victim_dirty = valid_q[victim][index] && dirty_q[victim][index];
    status.victim_tag   = way_tags[victim].tag;
  end

  //====================
  // state update
  //====================
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end
    else
    begin
      // refill brings in a clean, valid line
      if (ctrl.line_wen && ctrl.refill_sel)
      begin
        valid_q[way][index] <= 1'b1;
      end
      if (ctrl.clean_evict)
      begin
        dirty_q[way][index] <= 1'b0;
      end
      // an access makes the other way the next victim
      if (ctrl.touch)
      begin
        lru_q[index] <= ~way;
        if (write)
        begin
          dirty_q[way][index] <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/cache_way_array.sv ====
//====================
// one way of the cache, one entry per set
// contents are undefined after reset, validity is tracked elsewhere
//====================
`timescale 1ns/100ps

module cache_way_array #(
  parameter type entry_t = logic [31:0]
) (
  input  logic                            clk,
  input  logic [cache_pkg::index_w-1:0]   index,
  input  logic                            wen,
  input  entry_t                          wdata,
  output entry_t                          rdata
);

  entry_t mem_q [cache_pkg::num_sets];

  //====================
  // storage
  //====================

  // write lands on the edge
  always_ff @(posedge clk)
  begin
    if (wen)
    begin
      mem_q[index] <= wdata;
    end
  end

  // read is combinational, so a write shows up the next cycle
  always_comb
  begin
    rdata = mem_q[index];
  end

endmodule

// ==== vlog.f ====
verilog/cache_pkg.sv
verilog/cache_way_array.sv
verilog/cache_tag_check.sv
verilog/cache_datapath.sv
verilog/cache_ctrl.sv
verilog/blocking_cache.sv
verif/cache_mem_model.sv
verif/cache_tb.sv
